// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= boom_mem_tb
OBJ_DIR   ?= obj_dir

SRCS := $(wildcard hdl/*.sv) $(wildcard tb/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): src.f $(SRCS)
	$(VERILATOR) --binary --assert -j 0 --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP) -f src.f

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/boom_mem_pkg.sv ====
package boom_mem_pkg;

  // coherence directory geometry.
  localparam int DIR_ADDR_W = 10;
  localparam int DIR_LANES  = 8;
  localparam int DIR_LANE_W = 20;
  localparam int DIR_RAMS   = 3;

  // generic block RAM word and the pad that aligns lanes to bytes.
  localparam int RAM_W = 64;
  localparam int PAD_W = 4;

  // tag array geometry.
  localparam int TAG_ADDR_W = 6;
  localparam int TAG_WAYS   = 4;
  localparam int TAG_WAY_W  = 22;

  // predictor table geometry.
  localparam int TBL_ADDR_W = 7;
  localparam int TBL_LANES  = 4;
  localparam int TBL_LANE_W = 11;

  typedef logic [DIR_ADDR_W-1:0]           dir_addr_t;
  typedef logic [DIR_LANES*DIR_LANE_W-1:0] dir_word_t;
  typedef logic [DIR_LANES-1:0]            dir_mask_t;

  typedef logic [RAM_W-1:0]   ram_word_t;
  typedef logic [RAM_W/8-1:0] ram_be_t;

  typedef logic [TAG_ADDR_W-1:0]          tag_addr_t;
  typedef logic [TAG_WAYS*TAG_WAY_W-1:0]  tag_word_t;
  typedef logic [TAG_WAYS-1:0]            tag_mask_t;

  typedef logic [TBL_ADDR_W-1:0]           tbl_addr_t;
  typedef logic [TBL_LANES*TBL_LANE_W-1:0] tbl_word_t;
  typedef logic [TBL_LANES-1:0]            tbl_mask_t;

  // single read/write port where wmode picks write.
  typedef struct packed {
    logic      en;
    logic      wmode;
    dir_addr_t addr;
    dir_word_t wdata;
    dir_mask_t wmask;
  } dir_req_t;

  typedef struct packed {
    logic      en;
    tag_addr_t addr;
    tag_word_t data;
    tag_mask_t mask;
  } tag_wr_t;

  typedef struct packed {
    logic      en;
    tag_addr_t addr;
  } tag_rd_t;

  typedef struct packed {
    logic      en;
    tbl_addr_t addr;
    tbl_word_t data;
    tbl_mask_t mask;
  } tbl_wr_t;

  typedef struct packed {
    logic      en;
    tbl_addr_t addr;
  } tbl_rd_t;

endpackage

// ==== hdl/boom_mem_top.sv ====
`timescale 1ns/1ps

module boom_mem_top import boom_mem_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  // coherence directory.
  input  dir_req_t  dir_req,
  output dir_word_t dir_rdata,
  output logic      dir_rvalid,

  // tag array.
  input  tag_wr_t   tag_wr,
  input  tag_rd_t   tag_rd,
  output tag_word_t tag_rdata,
  output logic      tag_rvalid,

  // predictor table.
  input  tbl_wr_t   tbl_wr,
  input  tbl_rd_t   tbl_rd,
  output tbl_word_t tbl_rdata,
  output logic      tbl_rvalid
);

  cc_dir_ram u_dir (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (dir_req),
    .rdata  (dir_rdata),
    .rvalid (dir_rvalid)
  );

  tag_way_array u_tag (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr     (tag_wr),
    .rd     (tag_rd),
    .rdata  (tag_rdata),
    .rvalid (tag_rvalid)
  );

  predictor_table u_tbl (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr     (tbl_wr),
    .rd     (tbl_rd),
    .rdata  (tbl_rdata),
    .rvalid (tbl_rvalid)
  );

endmodule

// ==== hdl/cc_dir_ram.sv ====
`timescale 1ns/1ps

module cc_dir_ram import boom_mem_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  dir_req_t  req,
  output dir_word_t rdata,
  output logic      rvalid
);

  logic [DIR_RAMS*RAM_W-1:0]   wr_slots;
  logic [DIR_RAMS*RAM_W-1:0]   rd_slots;
  logic [DIR_RAMS*RAM_W/8-1:0] slot_be;

  // lane i sits at bit i*24 with its 20 data bits then a zero pad.
  // lanes 2 and 5 straddle two RAMs.
  for (genvar i = 0; i < DIR_LANES; i++) begin : g_lane
    assign wr_slots[i*(DIR_LANE_W+PAD_W) +: DIR_LANE_W] =
      req.wdata[i*DIR_LANE_W +: DIR_LANE_W];
    assign wr_slots[i*(DIR_LANE_W+PAD_W)+DIR_LANE_W +: PAD_W] = '0;
    assign rdata[i*DIR_LANE_W +: DIR_LANE_W] =
      rd_slots[i*(DIR_LANE_W+PAD_W) +: DIR_LANE_W];
  end

  // byte enable is the OR of every lane whose data bits touch the byte.
  always_comb begin
    slot_be = '0;
    for (int b = 0; b < DIR_RAMS*RAM_W/8; b++) begin
      for (int i = 0; i < DIR_LANES; i++) begin
        if (b*8 < i*(DIR_LANE_W+PAD_W)+DIR_LANE_W && b*8+8 > i*(DIR_LANE_W+PAD_W)) begin
          slot_be[b] = slot_be[b] | req.wmask[i];
        end
      end
    end
    slot_be = slot_be & {(DIR_RAMS*RAM_W/8){req.wmode}};
  end

  for (genvar k = 0; k < DIR_RAMS; k++) begin : g_ram
    ram_be_t ram_we;
    logic    ram_en;

    assign ram_we = slot_be[k*(RAM_W/8) +: RAM_W/8];
    // a bank with no bytes to write stays idle so its dout holds.
    assign ram_en = req.en & (~req.wmode | (|ram_we));

    sp_byte_ram #(
      .ADDR_W (DIR_ADDR_W)
    ) u_ram (
      .clk  (clk),
      .en   (ram_en),
      .we   (ram_we),
      .addr (req.addr),
      .din  (wr_slots[k*RAM_W +: RAM_W]),
      .dout (rd_slots[k*RAM_W +: RAM_W])
    );
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= req.en & ~req.wmode;
    end
  end

endmodule

// ==== hdl/predictor_table.sv ====
`timescale 1ns/1ps

module predictor_table import boom_mem_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  tbl_wr_t   wr,
  input  tbl_rd_t   rd,
  output tbl_word_t rdata,
  output logic      rvalid
);

  tbl_word_t wr_bits;

  // each lane mask bit covers all 11 bits of its lane.
  for (genvar i = 0; i < TBL_LANES; i++) begin : g_lane
    assign wr_bits[i*TBL_LANE_W +: TBL_LANE_W] = {TBL_LANE_W{wr.mask[i]}};
  end

  tp_ram #(
    .ADDR_W (TBL_ADDR_W),
    .DATA_W (TBL_LANES*TBL_LANE_W),
    .GRAIN  (1)
  ) u_ram (
    .clk     (clk),
    .wr_en   (wr.en),
    .wr_be   (wr_bits),
    .wr_addr (wr.addr),
    .wr_data (wr.data),
    .rd_en   (rd.en),
    .rd_addr (rd.addr),
    .rd_data (rdata)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= rd.en;
    end
  end

endmodule

// ==== hdl/sp_byte_ram.sv ====
`timescale 1ns/1ps

module sp_byte_ram import boom_mem_pkg::*; #(
  parameter int ADDR_W = 10
) (
  input  logic              clk,
  input  logic              en,
  input  ram_be_t           we,
  input  logic [ADDR_W-1:0] addr,
  input  ram_word_t         din,
  output ram_word_t         dout
);

  ram_word_t mem [2**ADDR_W];

  // no-change port.
  // a cycle with any byte enabled writes and leaves dout alone,
  // otherwise the addressed word is read out.
  always_ff @(posedge clk) begin
    if (en) begin
      if (|we) begin
        for (int b = 0; b < RAM_W/8; b++) begin
          if (we[b]) begin
            mem[addr][b*8 +: 8] <= din[b*8 +: 8];
          end
        end
      end else begin
        dout <= mem[addr];
      end
    end
  end

endmodule

// ==== hdl/tag_way_array.sv ====
`timescale 1ns/1ps

module tag_way_array import boom_mem_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  tag_wr_t   wr,
  input  tag_rd_t   rd,
  output tag_word_t rdata,
  output logic      rvalid
);

  // one RAM per way whose mask bit is its whole write enable.
  for (genvar n = 0; n < TAG_WAYS; n++) begin : g_way
    tp_ram #(
      .ADDR_W (TAG_ADDR_W),
      .DATA_W (TAG_WAY_W),
      .GRAIN  (TAG_WAY_W)
    ) u_way (
      .clk     (clk),
      .wr_en   (wr.en),
      .wr_be   (wr.mask[n]),
      .wr_addr (wr.addr),
      .wr_data (wr.data[n*TAG_WAY_W +: TAG_WAY_W]),
      .rd_en   (rd.en),
      .rd_addr (rd.addr),
      .rd_data (rdata[n*TAG_WAY_W +: TAG_WAY_W])
    );
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= rd.en;
    end
  end

endmodule

// ==== hdl/tp_ram.sv ====
`timescale 1ns/1ps

module tp_ram #(
  parameter int ADDR_W = 7,
  parameter int DATA_W = 44,
  parameter int GRAIN  = 1
) (
  input  logic                    clk,
  input  logic                    wr_en,
  input  logic [DATA_W/GRAIN-1:0] wr_be,
  input  logic [ADDR_W-1:0]       wr_addr,
  input  logic [DATA_W-1:0]       wr_data,
  input  logic                    rd_en,
  input  logic [ADDR_W-1:0]       rd_addr,
  output logic [DATA_W-1:0]       rd_data
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  // one enable bit per granule.
  // GRAIN of 8 gives byte writes, 1 gives bit writes.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int g = 0; g < DATA_W/GRAIN; g++) begin
        if (wr_be[g]) begin
          mem[wr_addr][g*GRAIN +: GRAIN] <= wr_data[g*GRAIN +: GRAIN];
        end
      end
    end
  end

  // read-first on a same-address collision.
  // rd_data keeps its value when rd_en is low.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== src.f ====
hdl/boom_mem_pkg.sv
hdl/sp_byte_ram.sv
hdl/tp_ram.sv
hdl/cc_dir_ram.sv
hdl/tag_way_array.sv
hdl/predictor_table.sv
hdl/boom_mem_top.sv
tb/boom_mem_properties.sv
tb/boom_mem_tb.sv

// ==== tb/boom_mem_properties.sv ====
`timescale 1ns/1ps

module boom_mem_properties import boom_mem_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input dir_req_t dir_req,
  input tag_rd_t  tag_rd,
  input tbl_rd_t  tbl_rd,
  input logic     dir_rvalid,
  input logic     tag_rvalid,
  input logic     tbl_rvalid
);

  logic dir_read;

  assign dir_read = dir_req.en & ~dir_req.wmode;

  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !dir_rvalid && !tag_rvalid && !tbl_rvalid)
    else $error("rvalid high during reset");

  a_dir_follow: assert property (@(posedge clk) disable iff (!rst_n)
    dir_read |=> dir_rvalid)
    else $error("dir_rvalid missing after a read");
  a_tag_follow: assert property (@(posedge clk) disable iff (!rst_n)
    tag_rd.en |=> tag_rvalid)
    else $error("tag_rvalid missing after a read");
  a_tbl_follow: assert property (@(posedge clk) disable iff (!rst_n)
    tbl_rd.en |=> tbl_rvalid)
    else $error("tbl_rvalid missing after a read");

  // no valid without a request the cycle before.
  a_dir_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(dir_rvalid) |-> $past(dir_read))
    else $error("dir_rvalid rose without a read");
  a_tag_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(tag_rvalid) |-> $past(tag_rd.en))
    else $error("tag_rvalid rose without a read");
  a_tbl_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(tbl_rvalid) |-> $past(tbl_rd.en))
    else $error("tbl_rvalid rose without a read");

endmodule

bind boom_mem_top boom_mem_properties u_props (.*);

// ==== tb/boom_mem_stim.txt ====
# target op addr data mask expected, all hex
# data r = lfsr word, expected m = shadow model, pair reads addr then the data column
dir write 010 0123456789abcdef0123456789abcdef01234567 ff -
dir read 010 - 00 0123456789abcdef0123456789abcdef01234567
dir write 010 ffffffffffffffffffffffffffffffffffffffff 24 -
dir read 010 - 00 0123456789ffffff012345678fffffef01234567
dir write 3ff r ff -
dir read 3ff - 00 m
dir write 3ff r 81 -
dir read 3ff - 00 m
dir write 3ff r 5a -
dir read 3ff - 00 m
dir write 3ff r 18 -
dir read 3ff - 00 m
dir write 200 r ff -
dir read 200 - 00 m
dir pair 3ff 010 00 m
dir pair 200 3ff 00 m
tag write 05 123456789abcdef0123456 f -
tag read 05 - 0 123456789abcdef0123456
tag write 05 r 5 -
tag read 05 - 0 m
tag write 05 r 8 -
tag read 05 - 0 m
tag write 3f r f -
tag read 3f - 0 m
tag rdwr 3f r 3 m
tag read 3f - 0 m
tag pair 05 3f 0 m
tbl write 11 0123456789a f -
tbl read 11 - 0 0123456789a
tbl write 00 r f -
tbl write 7f r f -
tbl read 00 - 0 m
tbl write 00 r 6 -
tbl read 00 - 0 m
tbl write 00 r 1 -
tbl read 00 - 0 m
tbl pair 00 7f 0 m
tbl pair 7f 11 0 m

// ==== tb/boom_mem_tb.sv ====
`timescale 1ns/1ps

module boom_mem_tb import boom_mem_pkg::*; ();

  logic      clk;
  logic      rst_n;
  dir_req_t  dir_req;
  dir_word_t dir_rdata;
  logic      dir_rvalid;
  tag_wr_t   tag_wr;
  tag_rd_t   tag_rd;
  tag_word_t tag_rdata;
  logic      tag_rvalid;
  tbl_wr_t   tbl_wr;
  tbl_rd_t   tbl_rd;
  tbl_word_t tbl_rdata;
  logic      tbl_rvalid;

  // shadow copies of what each macro should hold.
  dir_word_t dir_mem [int];
  tag_word_t tag_mem [int];
  tbl_word_t tbl_mem [int];

  logic [31:0] lfsr_state;
  int          errors;
  int          tests;
  int          bad_tests;
  bit          test_bad;

  boom_mem_top dut0 (.*);

  always #20 clk = ~clk;

  // galois lfsr stepped once for each bit taken.
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h80200003;
    end
    return out;
  endfunction

  function automatic logic [159:0] random_word(int n);
    logic [159:0] w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      w[i] = lfsr_bit();
    end
    return w;
  endfunction

  task automatic check_dir(string name, dir_word_t got, dir_word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h exp %h", name, got, exp);
      errors++;
      test_bad = 1;
    end
  endtask

  task automatic check_tag(string name, tag_word_t got, tag_word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h exp %h", name, got, exp);
      errors++;
      test_bad = 1;
    end
  endtask

  task automatic check_tbl(string name, tbl_word_t got, tbl_word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h exp %h", name, got, exp);
      errors++;
      test_bad = 1;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h exp %h", name, got, exp);
      errors++;
      test_bad = 1;
    end
  endtask

  function automatic logic valid_of(int tgt);
    if (tgt == 0) begin
      return dir_rvalid;
    end else if (tgt == 1) begin
      return tag_rvalid;
    end
    return tbl_rvalid;
  endfunction

  // sampled on the falling edge away from the driving edge.
  task automatic wait_valid(int tgt);
    int  n;
    bit  ok;
    n = 0;
    ok = 0;
    while (!ok && n < 10) begin
      @(negedge clk);
      n++;
      ok = (valid_of(tgt) === 1'b1);
    end
    if (!ok) begin
      $display("timeout: no read valid within 10 cycles on target %0d", tgt);
      errors++;
      test_bad = 1;
    end
  endtask

  function automatic logic [159:0] model_of(int tgt, int a);
    if (tgt == 0) begin
      return 160'(dir_mem[a]);
    end else if (tgt == 1) begin
      return 160'(tag_mem[a]);
    end
    return 160'(tbl_mem[a]);
  endfunction

  task automatic compare_read(int tgt, logic [159:0] exp);
    if (tgt == 0) begin
      check_dir("dir_rdata", dir_rdata, dir_word_t'(exp));
    end else if (tgt == 1) begin
      check_tag("tag_rdata", tag_rdata, tag_word_t'(exp));
    end else begin
      check_tbl("tbl_rdata", tbl_rdata, tbl_word_t'(exp));
    end
  endtask

  task automatic start_read(int tgt, logic [15:0] a);
    if (tgt == 0) begin
      dir_req <= '{en: 1'b1, wmode: 1'b0, addr: dir_addr_t'(a), wdata: '0, wmask: '0};
    end else if (tgt == 1) begin
      tag_rd <= '{en: 1'b1, addr: tag_addr_t'(a)};
    end else begin
      tbl_rd <= '{en: 1'b1, addr: tbl_addr_t'(a)};
    end
  endtask

  task automatic start_write(int tgt, logic [15:0] a, logic [159:0] d, logic [7:0] m);
    if (tgt == 0) begin
      dir_req <= '{en: 1'b1, wmode: 1'b1, addr: dir_addr_t'(a),
                   wdata: dir_word_t'(d), wmask: m};
    end else if (tgt == 1) begin
      tag_wr <= '{en: 1'b1, addr: tag_addr_t'(a), data: tag_word_t'(d),
                  mask: tag_mask_t'(m)};
    end else begin
      tbl_wr <= '{en: 1'b1, addr: tbl_addr_t'(a), data: tbl_word_t'(d),
                  mask: tbl_mask_t'(m)};
    end
  endtask

  task automatic idle_all();
    dir_req <= '0;
    tag_wr  <= '0;
    tag_rd  <= '0;
    tbl_wr  <= '0;
    tbl_rd  <= '0;
  endtask

  // masked lanes take the new data while the rest keep the old word.
  task automatic update_model(int tgt, int a, logic [159:0] d, logic [7:0] m);
    dir_word_t dw;
    tag_word_t tw;
    tbl_word_t bw;
    if (tgt == 0) begin
      dw = dir_mem.exists(a) ? dir_mem[a] : 'x;
      for (int i = 0; i < DIR_LANES; i++) begin
        if (m[i]) dw[i*DIR_LANE_W +: DIR_LANE_W] = d[i*DIR_LANE_W +: DIR_LANE_W];
      end
      dir_mem[a] = dw;
    end else if (tgt == 1) begin
      tw = tag_mem.exists(a) ? tag_mem[a] : 'x;
      for (int i = 0; i < TAG_WAYS; i++) begin
        if (m[i]) tw[i*TAG_WAY_W +: TAG_WAY_W] = d[i*TAG_WAY_W +: TAG_WAY_W];
      end
      tag_mem[a] = tw;
    end else begin
      bw = tbl_mem.exists(a) ? tbl_mem[a] : 'x;
      for (int i = 0; i < TBL_LANES; i++) begin
        if (m[i]) bw[i*TBL_LANE_W +: TBL_LANE_W] = d[i*TBL_LANE_W +: TBL_LANE_W];
      end
      tbl_mem[a] = bw;
    end
  endtask

  initial begin
    #(40 * 5000);
    $display("watchdog expired before the stimulus finished");
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int           fd;
    int           n;
    int           tgt;
    int           width;
    string        line;
    string        target;
    string        op;
    string        data_s;
    string        exp_s;
    string        vname;
    logic [15:0]  addr;
    logic [15:0]  addr_b;
    logic [159:0] data;
    logic [159:0] exp;
    logic [7:0]   mask;

    clk = 1'b0;
    rst_n = 1'b0;
    dir_req = '0;
    tag_wr = '0;
    tag_rd = '0;
    tbl_wr = '0;
    tbl_rd = '0;
    lfsr_state = 32'h44de5095;
    errors = 0;
    tests = 0;
    bad_tests = 0;

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    test_bad = 0;
    check_flag("dir_rvalid", dir_rvalid, 1'b0);
    check_flag("tag_rvalid", tag_rvalid, 1'b0);
    check_flag("tbl_rvalid", tbl_rvalid, 1'b0);
    tests++;
    if (test_bad) bad_tests++;
    $display("test %0d reset flags %s", tests, test_bad ? "bad" : "ok");

    fd = $fopen("tb/boom_mem_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file");
      errors++;
    end
    while (fd != 0 && !$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;
      n = $sscanf(line, "%s %s %h %s %h %s", target, op, addr, data_s, mask, exp_s);
      if (n != 6) begin
        $display("malformed stimulus line: %s", line);
        errors++;
        continue;
      end
      tgt = (target == "dir") ? 0 : (target == "tag") ? 1 : 2;
      width = (tgt == 0) ? 160 : (tgt == 1) ? 88 : 44;
      vname = (tgt == 0) ? "dir_rvalid" : (tgt == 1) ? "tag_rvalid" : "tbl_rvalid";
      data = '0;
      addr_b = '0;
      if (data_s == "r") begin
        data = random_word(width);
      end else if (data_s != "-") begin
        n = $sscanf(data_s, "%h", data);
        addr_b = data[15:0];
      end
      exp = '0;
      if (exp_s != "m" && exp_s != "-") begin
        n = $sscanf(exp_s, "%h", exp);
      end else if (exp_s == "m") begin
        exp = model_of(tgt, int'(addr));
      end
      test_bad = 0;

      @(posedge clk);
      if (op == "write") begin
        start_write(tgt, addr, data, mask);
        @(posedge clk);
        idle_all();
        update_model(tgt, int'(addr), data, mask);
      end else if (op == "read") begin
        start_read(tgt, addr);
        @(posedge clk);
        idle_all();
        wait_valid(tgt);
        compare_read(tgt, exp);
        @(negedge clk);
        check_flag(vname, valid_of(tgt), 1'b0);
      end else if (op == "rdwr") begin
        // same-address collision returns the old word.
        start_write(tgt, addr, data, mask);
        start_read(tgt, addr);
        @(posedge clk);
        idle_all();
        start_read(tgt, addr);
        wait_valid(tgt);
        compare_read(tgt, exp);
        update_model(tgt, int'(addr), data, mask);
        // the read right behind it sees the new word.
        @(posedge clk);
        idle_all();
        @(negedge clk);
        check_flag(vname, valid_of(tgt), 1'b1);
        compare_read(tgt, model_of(tgt, int'(addr)));
      end else begin
        start_read(tgt, addr);
        @(posedge clk);
        start_read(tgt, addr_b);
        wait_valid(tgt);
        compare_read(tgt, exp);
        @(posedge clk);
        idle_all();
        @(negedge clk);
        check_flag(vname, valid_of(tgt), 1'b1);
        compare_read(tgt, model_of(tgt, int'(addr_b)));
      end

      tests++;
      if (test_bad) bad_tests++;
      $display("test %0d %s %s %h %s", tests, target, op, addr, test_bad ? "bad" : "ok");
    end
    if (fd != 0) $fclose(fd);

    repeat (2) @(posedge clk);
    $display("tests %0d, bad %0d, errors %0d", tests, bad_tests, errors);
    if (errors == 0 && bad_tests == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
